// File: build.f
src/rep_params_pkg.sv
src/rep_types_pkg.sv
src/rep_job_if.sv
src/rep_fifo.sv
src/rep_classifier.sv
src/rep_scheduler.sv
src/rep_top.sv
tests/rep_asserts.sv
tests/tb_rep_top.sv

// File: Makefile
# Verilator build and run for the packet replicator

VERILATOR ?= verilator
TOP ?= tb_rep_top
LINT_TOP ?= rep_top
FILE_LIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
RUN_ARGS ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_rep_top.sv
/*
 * Testbench for the packet replicator
 * clock and reset, packet stimulus under back-pressure, reference model of
 * the expected copies and discards, and the comparing process
 */

module tb_rep_top
	import rep_params_pkg::*, rep_types_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic discard;
		logic allow_mcast;
		logic [conn_vec_w-1:0] vec;
		logic [pri_w-1:0] pri;
		pkt_desc_t desc;
	} pkt_t;

	typedef struct {
		int at_cycle;	// compare cycle that must see discard_req
		pkt_desc_t desc;
	} disc_t;

	logic clk;
	logic reset;
	logic enq_req;
	logic enq_discard;
	logic enq_allow_mcast;
	logic [conn_vec_w-1:0] enq_vec;
	logic [pri_w-1:0] enq_pri;
	logic [buf_ptr_w-1:0] enq_buf_ptr;
	logic [len_w-1:0] enq_len;
	logic [src_port_w-1:0] enq_src_port;
	logic int_rep_bp;
	logic discard_req;
	logic [buf_ptr_w-1:0] discard_buf_ptr;
	logic [len_w-1:0] discard_len;
	logic [src_port_w-1:0] discard_src_port;
	logic rep_enq_req;
	logic rep_enq_ucast;
	logic rep_enq_last;
	logic [conn_w-1:0] rep_enq_packet_id;
	logic [qid_w-1:0] rep_enq_qid;
	logic [buf_ptr_w-1:0] rep_enq_buf_ptr;
	logic [len_w-1:0] rep_enq_len;
	logic [src_port_w-1:0] rep_enq_src_port;

	int seed = 32'hd5a59331;
	int cycle = 0;
	int mismatches = 0;
	int other_errors = 0;
	int bp_mode = 0;	// 0 off, 1 random, 2 held high
	int mcast_pend = 0;	// multicast jobs waiting in the job queue
	logic in_service = 1'b0;	// a multicast job is held by the scheduler
	logic [buf_ptr_w-1:0] next_ptr = '0;	// unique buffer pointer per packet
	rep_copy_t exp_copies[$];
	disc_t disc_q[$];

	rep_top dut (
		.clk(clk),
		.reset(reset),
		.enq_req(enq_req),
		.enq_discard(enq_discard),
		.enq_allow_mcast(enq_allow_mcast),
		.enq_vec(enq_vec),
		.enq_pri(enq_pri),
		.enq_buf_ptr(enq_buf_ptr),
		.enq_len(enq_len),
		.enq_src_port(enq_src_port),
		.int_rep_bp(int_rep_bp),
		.discard_req(discard_req),
		.discard_buf_ptr(discard_buf_ptr),
		.discard_len(discard_len),
		.discard_src_port(discard_src_port),
		.rep_enq_req(rep_enq_req),
		.rep_enq_ucast(rep_enq_ucast),
		.rep_enq_last(rep_enq_last),
		.rep_enq_packet_id(rep_enq_packet_id),
		.rep_enq_qid(rep_enq_qid),
		.rep_enq_buf_ptr(rep_enq_buf_ptr),
		.rep_enq_len(rep_enq_len),
		.rep_enq_src_port(rep_enq_src_port)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ********************************************************************
	// reference model returns the copy count or 0 for a discard

	function automatic int expected_copies(input pkt_t p, input int mcast_occ,
		output rep_copy_t copies [conn_vec_w]);
		int n;
		int k;
		n = 0;
		k = 0;
		for (int i = 0; i < conn_vec_w; i++)
			n = n + int'(p.vec[i]);
		if (p.discard || n == 0)
			return 0;
		if (n > 1 && (!p.allow_mcast || mcast_occ >= (1 << job_depth_log2)))
			return 0;	// multicast not allowed or its queue is full
		for (int i = 0; i < conn_vec_w; i++)
			if (p.vec[i])
			begin
				copies[k].ucast = (n == 1);
				copies[k].last = (k == n - 1);
				copies[k].idx = conn_w'(k);
				copies[k].qid = {p.pri, conn_w'(i)};	// priority then connection
				copies[k].desc = p.desc;
				k++;
			end
		return n;
	endfunction

	function automatic pkt_t make_packet(input logic [conn_vec_w-1:0] vec,
		input logic allow_mcast, input logic discard);
		pkt_t p;
		p.discard = discard;
		p.allow_mcast = allow_mcast;
		p.vec = vec;
		p.pri = pri_w'($random(seed));
		p.desc.buf_ptr = next_ptr;
		p.desc.len = len_w'($random(seed));
		p.desc.src_port = src_port_w'($random(seed));
		next_ptr = next_ptr + 1'b1;
		return p;
	endfunction

	// random vector with at least two connections set
	function automatic logic [conn_vec_w-1:0] multi_vec();
		int a;
		int b;
		logic [conn_vec_w-1:0] v;
		v = conn_vec_w'($random(seed) & $random(seed));
		a = $random(seed) & (conn_vec_w - 1);
		b = (a + 1 + ($random(seed) & 7)) & (conn_vec_w - 1);
		v[a] = 1'b1;
		v[b] = 1'b1;
		return v;
	endfunction

	// ********************************************************************
	// stimulus driven on the falling edge

	task automatic next_negedge();
		@(negedge clk);
		if (bp_mode == 1)
			int_rep_bp = 1'($random(seed));
		else
			int_rep_bp = (bp_mode == 2);
	endtask

	task automatic send_packet(input pkt_t p);
		rep_copy_t copies [conn_vec_w];
		disc_t d;
		int n;
		next_negedge();
		n = expected_copies(p, mcast_pend, copies);
		if (n == 0)
		begin
			d.at_cycle = cycle + 3;	// sampled at the next edge and pulsed two edges later
			d.desc = p.desc;
			disc_q.push_back(d);
		end
		else
		begin
			for (int i = 0; i < n; i++)
				exp_copies.push_back(copies[i]);
			if (n > 1 && in_service)
				mcast_pend++;
			else if (n > 1)
				in_service = 1'b1;
		end
		enq_req = 1'b1;
		enq_discard = p.discard;
		enq_allow_mcast = p.allow_mcast;
		enq_vec = p.vec;
		enq_pri = p.pri;
		enq_buf_ptr = p.desc.buf_ptr;
		enq_len = p.desc.len;
		enq_src_port = p.desc.src_port;
	endtask

	task automatic end_burst();
		next_negedge();
		enq_req = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while ((exp_copies.size() > 0 || disc_q.size() > 0) && waited < 4000)
		begin
			next_negedge();
			waited++;
		end
		assert (exp_copies.size() == 0 && disc_q.size() == 0)
		else
		begin
			other_errors++;
			$display("timeout at %0t with %0d copies and %0d discards outstanding",
				$time, exp_copies.size(), disc_q.size());
		end
		mcast_pend = 0;
		in_service = 1'b0;
	endtask

	// ********************************************************************
	// comparing process samples at the rising edge

	task automatic compare_value(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			mismatches++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_discard();
		disc_t d;
		logic due;
		due = (disc_q.size() > 0) && (disc_q[0].at_cycle == cycle);
		if (due)
			d = disc_q.pop_front();
		assert (discard_req == due)
		else
		begin
			other_errors++;
			if (due)
				$display("discard_req missing at %0t for buffer %h", $time, d.desc.buf_ptr);
			else
				$display("unexpected discard_req at %0t for buffer %h", $time, discard_buf_ptr);
		end
		if (due && discard_req)
		begin
			compare_value("discard_buf_ptr", discard_buf_ptr, d.desc.buf_ptr);
			compare_value("discard_len", discard_len, d.desc.len);
			compare_value("discard_src_port", discard_src_port, d.desc.src_port);
		end
	endtask

	task automatic check_copy();
		rep_copy_t e;
		int pos;
		pos = -1;
		for (int i = 0; i < exp_copies.size(); i++)
			if (pos < 0 && exp_copies[i].desc.buf_ptr == rep_enq_buf_ptr)
				pos = i;	// oldest pending copy of this packet
		assert (pos >= 0)
		else
		begin
			other_errors++;
			$display("copy of buffer %h at %0t was not expected", rep_enq_buf_ptr, $time);
		end
		if (pos >= 0)
		begin
			e = exp_copies[pos];
			exp_copies.delete(pos);
			compare_value("rep_enq_ucast", rep_enq_ucast, e.ucast);
			compare_value("rep_enq_last", rep_enq_last, e.last);
			compare_value("rep_enq_packet_id", rep_enq_packet_id, e.idx);
			compare_value("rep_enq_qid", rep_enq_qid, e.qid);
			compare_value("rep_enq_len", rep_enq_len, e.desc.len);
			compare_value("rep_enq_src_port", rep_enq_src_port, e.desc.src_port);
		end
	endtask

	always @(posedge clk)
	begin
		cycle = cycle + 1;
		if (!reset)
		begin
			check_discard();
			if (rep_enq_req)
				check_copy();
		end
	end

	// ********************************************************************
	// test sequence

	initial
	begin
		int burst_len;
		reset = 1'b1;
		enq_req = 1'b0;
		enq_discard = 1'b0;
		enq_allow_mcast = 1'b0;
		enq_vec = '0;
		enq_pri = '0;
		enq_buf_ptr = '0;
		enq_len = '0;
		enq_src_port = '0;
		int_rep_bp = 1'b0;
		repeat (10) next_negedge();
		reset = 1'b0;

		for (int i = 0; i < conn_vec_w; i++)	// unicast on every connection
			send_packet(make_packet(conn_vec_w'(1) << i, 1'($random(seed)), 1'b0));
		end_burst();
		drain();

		send_packet(make_packet('1, 1'b1, 1'b0));	// multicast
		send_packet(make_packet(16'h8001, 1'b1, 1'b0));
		for (int i = 0; i < 10; i++)
			send_packet(make_packet(multi_vec(), 1'b1, 1'b0));
		end_burst();
		drain();

		for (int i = 0; i < 3; i++)	// discards mixed with good packets
		begin
			send_packet(make_packet(16'h0010, 1'b1, 1'b0));
			send_packet(make_packet(multi_vec(), 1'b1, 1'b1));
			send_packet(make_packet(16'h0004, 1'b1, 1'b1));
			send_packet(make_packet('0, 1'b1, 1'b0));
			send_packet(make_packet(multi_vec(), 1'b0, 1'b0));
			send_packet(make_packet(multi_vec(), 1'b1, 1'b0));
		end
		end_burst();
		drain();

		bp_mode = 1;	// random back-pressure with bursts below the queue depths
		for (int b = 0; b < 20; b++)
		begin
			burst_len = ($random(seed) & 7) + 5;
			for (int i = 0; i < burst_len; i++)
				case ($random(seed) & 7)
					0: send_packet(make_packet(conn_vec_w'($random(seed)), 1'b1, 1'b1));
					1: send_packet(make_packet('0, 1'b1, 1'b0));
					2: send_packet(make_packet(multi_vec(), 1'b0, 1'b0));
					3, 4: send_packet(make_packet(conn_vec_w'(1) << ($random(seed) & 15),
						1'($random(seed)), 1'b0));
					default: send_packet(make_packet(multi_vec(), 1'b1, 1'b0));
				endcase
			end_burst();
			drain();
		end

		bp_mode = 2;	// fill the multicast queue
		repeat (4) next_negedge();
		for (int i = 0; i < 19; i++)
			send_packet(make_packet('1, 1'b1, 1'b0));
		end_burst();
		repeat (20) next_negedge();
		bp_mode = 0;
		drain();

		repeat (20) next_negedge();
		other_errors = other_errors + dut.u_asserts.fail_count;
		$display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: tests/rep_asserts.sv
/*
 * Concurrent checks bound to the replicator top level
 * back-pressure gating, unicast copies marked last, quiet outputs in reset
 */

module rep_asserts (
	input logic clk,
	input logic reset,
	input logic int_rep_bp,
	input logic rep_enq_req,
	input logic rep_enq_ucast,
	input logic rep_enq_last,
	input logic discard_req
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;	// read by the testbench at the end of the run

	no_req_under_bp: assert property (@(posedge clk) int_rep_bp |-> !rep_enq_req)
	else
	begin
		fail_count++;
		$error("rep_enq_req high while int_rep_bp is high");
	end

	ucast_is_last: assert property (@(posedge clk) disable iff (reset)
		(rep_enq_req && rep_enq_ucast) |-> rep_enq_last)
	else
	begin
		fail_count++;
		$error("unicast copy without rep_enq_last");
	end

	// first reset edge clears the registers
	quiet_in_reset: assert property (@(posedge clk)
		(reset && $past(reset)) |-> (!discard_req && !rep_enq_req))
	else
	begin
		fail_count++;
		$error("discard_req or rep_enq_req high during reset");
	end

endmodule

bind rep_top rep_asserts u_asserts (.*);

// File: src/rep_top.sv
/*
 * Packet replicator top level
 * classifier, scheduler, output queue and consumer back-pressure gating
 */

module rep_top
	import rep_params_pkg::*, rep_types_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic enq_req,
	input logic enq_discard,
	input logic enq_allow_mcast,
	input logic [conn_vec_w-1:0] enq_vec,
	input logic [pri_w-1:0] enq_pri,
	input logic [buf_ptr_w-1:0] enq_buf_ptr,
	input logic [len_w-1:0] enq_len,
	input logic [src_port_w-1:0] enq_src_port,

	input logic int_rep_bp,

	output logic discard_req,
	output logic [buf_ptr_w-1:0] discard_buf_ptr,
	output logic [len_w-1:0] discard_len,
	output logic [src_port_w-1:0] discard_src_port,

	output logic rep_enq_req,
	output logic rep_enq_ucast,
	output logic rep_enq_last,
	output logic [conn_w-1:0] rep_enq_packet_id,
	output logic [qid_w-1:0] rep_enq_qid,
	output logic [buf_ptr_w-1:0] rep_enq_buf_ptr,
	output logic [len_w-1:0] rep_enq_len,
	output logic [src_port_w-1:0] rep_enq_src_port
);

	rep_job_if jobs ();

	pkt_desc_t enq_desc;
	pkt_desc_t discard_desc;

	logic copy_wr;
	rep_copy_t copy;
	logic copy_full;
	rep_copy_t out_copy;
	logic out_empty;

	assign enq_desc.buf_ptr = enq_buf_ptr;
	assign enq_desc.len = enq_len;
	assign enq_desc.src_port = enq_src_port;

	rep_classifier u_classifier (
		.clk(clk),
		.reset(reset),
		.enq_req(enq_req),
		.enq_discard(enq_discard),
		.enq_allow_mcast(enq_allow_mcast),
		.enq_vec(enq_vec),
		.enq_pri(enq_pri),
		.enq_desc(enq_desc),
		.jobs(jobs.classifier),
		.discard_req(discard_req),
		.discard_desc(discard_desc)
	);

	rep_scheduler u_scheduler (
		.clk(clk),
		.reset(reset),
		.jobs(jobs.scheduler),
		.copy_wr(copy_wr),
		.copy(copy),
		.copy_full(copy_full)
	);

	// ****************************************************************
	// output queue, popped by every delivered copy

	rep_fifo #(
		.width($bits(rep_copy_t)),
		.depth_log2(out_depth_log2)
	) u_out_fifo (
		.clk(clk),
		.reset(reset),
		.wr(copy_wr),
		.din(copy),
		.rd(rep_enq_req),
		.dout(out_copy),
		.full(copy_full),
		.empty(out_empty)
	);

	assign rep_enq_req = ~out_empty & ~int_rep_bp;	// consumer takes one per cycle

	assign rep_enq_ucast = out_copy.ucast;
	assign rep_enq_last = out_copy.last;
	assign rep_enq_packet_id = out_copy.idx;
	assign rep_enq_qid = out_copy.qid;
	assign rep_enq_buf_ptr = out_copy.desc.buf_ptr;
	assign rep_enq_len = out_copy.desc.len;
	assign rep_enq_src_port = out_copy.desc.src_port;

	assign discard_buf_ptr = discard_desc.buf_ptr;
	assign discard_len = discard_desc.len;
	assign discard_src_port = discard_desc.src_port;

endmodule

// File: src/rep_scheduler.sv
/*
 * Replication scheduler
 * unicast and multicast job queues, current job register and the loop
 * that emits one copy per set connection bit, lowest connection first
 */

module rep_scheduler
	import rep_params_pkg::*, rep_types_pkg::*;
(
	input logic clk,
	input logic reset,
	rep_job_if.scheduler jobs,
	output logic copy_wr,
	output rep_copy_t copy,
	input logic copy_full
);

	rep_job_t u_dout;
	rep_job_t m_dout;
	logic u_empty;
	logic m_empty;
	logic u_rd;
	logic m_rd;

	rep_job_t next_job;
	rep_job_t cur_job;	// vec holds the connections still to be sent
	logic cur_valid;
	logic [conn_w-1:0] cur_idx;

	logic [conn_w-1:0] sel_conn;
	logic [conn_vec_w-1:0] sel_bit;
	logic last_copy;
	logic load;

	// lowest set bit of the vector
	function automatic logic [conn_w-1:0] low_conn(input logic [conn_vec_w-1:0] vec);
		logic [conn_w-1:0] idx;
		idx = '0;
		for (int i = conn_vec_w - 1; i >= 0; i--)
			if (vec[i])
				idx = conn_w'(i);
		return idx;
	endfunction

	// ****************************************************************
	// job queues

	rep_fifo #(
		.width($bits(rep_job_t)),
		.depth_log2(job_depth_log2)
	) u_ucast_fifo (
		.clk(clk),
		.reset(reset),
		.wr(jobs.ucast_wr),
		.din(jobs.job),
		.rd(u_rd),
		.dout(u_dout),
		.full(),	// no overflow check on unicast
		.empty(u_empty)
	);

	rep_fifo #(
		.width($bits(rep_job_t)),
		.depth_log2(job_depth_log2)
	) u_mcast_fifo (
		.clk(clk),
		.reset(reset),
		.wr(jobs.mcast_wr),
		.din(jobs.job),
		.rd(m_rd),
		.dout(m_dout),
		.full(jobs.mcast_full),
		.empty(m_empty)
	);

	// ****************************************************************
	// job selection, unicast first

	assign load = ~cur_valid | (copy_wr & last_copy);
	assign u_rd = load & ~u_empty;
	assign m_rd = load & u_empty & ~m_empty;
	assign next_job = u_empty ? m_dout : u_dout;

	always_ff @(posedge clk)
		if (reset)
			cur_valid <= 1'b0;
		else if (load)
			cur_valid <= ~u_empty | ~m_empty;

	always_ff @(posedge clk)
		if (load)
		begin
			cur_job <= next_job;
			cur_idx <= '0;
		end
		else if (copy_wr)
		begin
			cur_job.vec <= cur_job.vec & ~sel_bit;	// connection served
			cur_idx <= cur_idx + 1'b1;
		end

	// ****************************************************************
	// copy generation

	assign sel_conn = low_conn(cur_job.vec);
	assign sel_bit = conn_vec_w'(1) << sel_conn;
	assign last_copy = ({1'b0, cur_idx} == cur_job.count - 1'b1);

	assign copy_wr = cur_valid & ~copy_full;

	always_comb
	begin
		copy.ucast = (cur_job.count == count_w'(1));
		copy.last = last_copy;
		copy.idx = cur_idx;
		copy.qid = {cur_job.pri, sel_conn};
		copy.desc = cur_job.desc;
	end

endmodule

// File: src/rep_classifier.sv
/*
 * Input stage of the replicator
 * input register, set-bit count, unicast/multicast/discard decision,
 * registered discard pulse and descriptor
 */

module rep_classifier
	import rep_params_pkg::*, rep_types_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic enq_req,
	input logic enq_discard,
	input logic enq_allow_mcast,
	input logic [conn_vec_w-1:0] enq_vec,
	input logic [pri_w-1:0] enq_pri,
	input pkt_desc_t enq_desc,
	rep_job_if.classifier jobs,
	output logic discard_req,
	output pkt_desc_t discard_desc
);

	logic req_d1;
	logic discard_d1;
	logic allow_mcast_d1;
	logic [conn_vec_w-1:0] vec_d1;
	logic [pri_w-1:0] pri_d1;
	pkt_desc_t desc_d1;

	logic [count_w-1:0] count_d1;
	logic is_empty;
	logic is_ucast;
	logic is_mcast;
	logic discard_set;

	function automatic logic [count_w-1:0] pop_count(input logic [conn_vec_w-1:0] vec);
		logic [count_w-1:0] sum;
		sum = '0;
		for (int i = 0; i < conn_vec_w; i++)
			sum = sum + vec[i];
		return sum;
	endfunction

	// ****************************************************************
	// input register

	always_ff @(posedge clk)
		if (reset)
			req_d1 <= 1'b0;
		else
			req_d1 <= enq_req;

	always_ff @(posedge clk)
	begin
		discard_d1 <= enq_discard;
		allow_mcast_d1 <= enq_allow_mcast;
		vec_d1 <= enq_vec;
		pri_d1 <= enq_pri;
		desc_d1 <= enq_desc;
	end

	// ****************************************************************
	// path decision

	assign count_d1 = pop_count(vec_d1);
	assign is_empty = (count_d1 == '0);
	assign is_ucast = (count_d1 == count_w'(1));
	assign is_mcast = ~is_empty & ~is_ucast;

	assign jobs.ucast_wr = req_d1 & ~discard_d1 & is_ucast;
	assign jobs.mcast_wr = req_d1 & ~discard_d1 & is_mcast & allow_mcast_d1 & ~jobs.mcast_full;
	assign discard_set = req_d1 & (discard_d1 | is_empty |
		(is_mcast & (~allow_mcast_d1 | jobs.mcast_full)));

	assign jobs.job.vec = vec_d1;
	assign jobs.job.pri = pri_d1;
	assign jobs.job.count = count_d1;
	assign jobs.job.desc = desc_d1;

	// ****************************************************************
	// discard output, two clocks after enq_req

	always_ff @(posedge clk)
		if (reset)
			discard_req <= 1'b0;
		else
			discard_req <= discard_set;

	always_ff @(posedge clk)
		if (discard_set)
			discard_desc <= desc_d1;	// held until the next discard

endmodule

// File: src/rep_fifo.sv
/*
 * Synchronous register-array queue
 * head shown combinationally, full and empty levels
 */

module rep_fifo #(
	parameter int width = 8,
	parameter int depth_log2 = 4
)(
	input logic clk,
	input logic reset,
	input logic wr,
	input logic [width-1:0] din,
	input logic rd,
	output logic [width-1:0] dout,
	output logic full,
	output logic empty
);

	localparam int depth = 1 << depth_log2;

	logic [width-1:0] mem [depth];
	logic [depth_log2-1:0] wr_ptr;
	logic [depth_log2-1:0] rd_ptr;
	logic [depth_log2:0] count;

	logic wr_en;
	logic rd_en;

	assign wr_en = wr & ~full;	// writes into a full queue are lost
	assign rd_en = rd & ~empty;

	assign full = (count == (depth_log2+1)'(depth));
	assign empty = (count == '0);
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk)
		if (wr_en)
			mem[wr_ptr] <= din;

	always_ff @(posedge clk)
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + wr_en - rd_en;	// both at once keeps the level
		end

endmodule

// File: src/rep_job_if.sv
/*
 * Job path between classifier and scheduler
 * unicast and multicast write strobes, job record, multicast full level
 */

interface rep_job_if
	import rep_types_pkg::*;
();

	logic ucast_wr;	// write job into unicast queue
	logic mcast_wr;	// write job into multicast queue
	rep_job_t job;
	logic mcast_full;

	modport classifier (
		output ucast_wr,
		output mcast_wr,
		output job,
		input mcast_full
	);

	modport scheduler (
		input ucast_wr,
		input mcast_wr,
		input job,
		output mcast_full
	);

endinterface

// File: src/rep_types_pkg.sv
/*
 * Replicator record formats
 * packet descriptor, replication job and output copy
 */

package rep_types_pkg;

	import rep_params_pkg::*;

	// 26 bits
	typedef struct packed {
		logic [buf_ptr_w-1:0] buf_ptr;
		logic [len_w-1:0] len;
		logic [src_port_w-1:0] src_port;
	} pkt_desc_t;

	// 49 bits, one queued packet waiting for replication
	typedef struct packed {
		logic [conn_vec_w-1:0] vec;
		logic [pri_w-1:0] pri;
		logic [count_w-1:0] count;	// number of set bits in vec
		pkt_desc_t desc;
	} rep_job_t;

	// 38 bits, one enqueue toward the consumer
	typedef struct packed {
		logic ucast;
		logic last;
		logic [conn_w-1:0] idx;	// copy index within the packet
		logic [qid_w-1:0] qid;
		pkt_desc_t desc;
	} rep_copy_t;

endpackage

// File: src/rep_params_pkg.sv
/*
 * Replicator sizing constants
 * connection vector, priority, descriptor field widths and queue depths
 */

package rep_params_pkg;

	// connection vector and derived index widths
	localparam int conn_vec_w = 16;
	localparam int conn_w = 4;
	localparam int count_w = conn_w + 1;	// holds 0..conn_vec_w

	// queue id is {priority, connection}
	localparam int pri_w = 2;
	localparam int qid_w = pri_w + conn_w;

	// descriptor fields
	localparam int buf_ptr_w = 12;
	localparam int len_w = 10;
	localparam int src_port_w = 4;

	// queue depths as log2
	localparam int job_depth_log2 = 4;	// unicast and multicast job queues
	localparam int out_depth_log2 = 2;	// output queue in front of the consumer

endpackage
